//--- source/stripedFifoPkg.sv
// --------------------
// Striped FIFO shared definitions
// Sizing constants, the stream beat and the small index and count types
// used by every block of the striped flop-RAM FIFO
// --------------------

`default_nettype none

package stripedFifoPkg;

  // --------------------
  // Sizing
  // --------------------

  // Number of lane FIFOs that the input stream is striped across
  localparam int NumLanes = 4;

  // Entries held by each lane, must be at least 2
  localparam int LaneDepth = 4;

  // Payload data width carried by every beat
  localparam int DataWidth = 32;

  // Width of a lane index used by the spreader and gatherer pointers
  localparam int LaneIdxWidth = $clog2(NumLanes);

  // Width of a lane RAM address
  localparam int AddrWidth = $clog2(LaneDepth);

  // Width of an occupancy count, which has to hold 0 up to LaneDepth inclusive
  localparam int CountWidth = $clog2(LaneDepth + 1);

  // --------------------
  // Types
  // --------------------

  // One stream beat, also the word stored in each RAM entry
  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 last;
  } beat_t;

  // Lane index, wraps modulo NumLanes
  typedef logic [LaneIdxWidth-1:0] laneIdx_t;

  // Lane occupancy or free-slot count
  typedef logic [CountWidth-1:0] count_t;

endpackage : stripedFifoPkg

`default_nettype wire

//--- source/flopRam.sv
// --------------------
// Flop RAM, one write port and one read port
// Registered write at the clock edge, combinational read by address
// --------------------

`timescale 1ns/1ps
`default_nettype none

module flopRam (
  // Posedge clock shared by both ports
  input  logic                                 clk,
  // Asynchronous active-low reset, only used to block writes
  input  logic                                 rstN,

  // Write port
  input  logic                                 wrValid,
  input  logic [stripedFifoPkg::AddrWidth-1:0] wrAddr,
  input  stripedFifoPkg::beat_t                wrData,

  // Read port
  input  logic [stripedFifoPkg::AddrWidth-1:0] rdAddr,
  output stripedFifoPkg::beat_t                rdData
);

  // --------------------
  // Storage
  // --------------------

  // The entries carry no reset value
  // The FIFO control only reads an entry after it has been written
  stripedFifoPkg::beat_t mem [stripedFifoPkg::LaneDepth];

  // Writes are ignored while reset is held so that a push racing reset
  // cannot leave a stray entry behind
  always_ff @(posedge clk) begin
    if (wrValid && rstN) begin
      mem[wrAddr] <= wrData;
    end
  end

  // --------------------
  // Read
  // --------------------

  // Plain mux on the read address, no read latency
  assign rdData = mem[rdAddr];

endmodule : flopRam

`default_nettype wire

//--- source/fifoFlops.sv
// --------------------
// Lane FIFO on a flop RAM
// Ready/valid push and pop with pointer and count control and status flags
// Non-bypass, so a push is visible at the pop side one cycle later
// --------------------

`timescale 1ns/1ps
`default_nettype none

module fifoFlops (
  // Posedge clock
  input  logic                   clk,
  // Asynchronous active-low reset
  input  logic                   rstN,

  // Push side
  input  logic                   pushValid,
  input  stripedFifoPkg::beat_t  pushBeat,
  output logic                   pushReady,

  // Pop side
  output logic                   popValid,
  output stripedFifoPkg::beat_t  popBeat,
  input  logic                   popReady,

  // Status
  output logic                   full,
  output logic                   empty,
  output stripedFifoPkg::count_t items,
  output stripedFifoPkg::count_t slots
);

  // --------------------
  // Handshakes
  // --------------------

  logic                                 push;
  logic                                 pop;
  logic [stripedFifoPkg::AddrWidth-1:0] wrPtr;
  logic [stripedFifoPkg::AddrWidth-1:0] rdPtr;

  // RAM side of the lane
  logic                                 ramWrValid;
  logic [stripedFifoPkg::AddrWidth-1:0] ramWrAddr;
  stripedFifoPkg::beat_t                ramWrData;
  logic [stripedFifoPkg::AddrWidth-1:0] ramRdAddr;
  stripedFifoPkg::beat_t                ramRdData;

  // A transfer on either side needs both valid and ready in the same cycle
  assign push = pushValid && pushReady;
  assign pop  = popValid && popReady;

  // --------------------
  // Pointers
  // --------------------

  // Both pointers wrap at LaneDepth, which need not be a power of two
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
    end else if (push) begin
      if (int'(wrPtr) == stripedFifoPkg::LaneDepth - 1) begin
        wrPtr <= '0;
      end else begin
        wrPtr <= wrPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdPtr <= '0;
    end else if (pop) begin
      if (int'(rdPtr) == stripedFifoPkg::LaneDepth - 1) begin
        rdPtr <= '0;
      end else begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  // --------------------
  // Occupancy
  // --------------------

  // Push and pop in the same cycle leave the count where it is
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      items <= '0;
    end else begin
      case ({push, pop})
        2'b10:   items <= items + 1'b1;
        2'b01:   items <= items - 1'b1;
        default: items <= items;
      endcase
    end
  end

  // Status comes straight off the count register
  assign full      = (int'(items) == stripedFifoPkg::LaneDepth);
  assign empty     = (items == '0);
  assign slots     = stripedFifoPkg::count_t'(stripedFifoPkg::LaneDepth) - items;
  assign pushReady = !full;
  assign popValid  = !empty;

  // --------------------
  // RAM
  // --------------------

  // Writes land at the tail, the head is read from the read pointer
  // A write only goes to a free entry, so it never touches the head
  // that is being popped in the same cycle
  assign ramWrValid = push;
  assign ramWrAddr  = wrPtr;
  assign ramWrData  = pushBeat;
  assign ramRdAddr  = rdPtr;

  flopRam flopRam (
    .clk,
    .rstN,
    .wrValid(ramWrValid),
    .wrAddr (ramWrAddr),
    .wrData (ramWrData),
    .rdAddr (ramRdAddr),
    .rdData (ramRdData)
  );

  // Head of the lane, valid whenever the lane is not empty
  assign popBeat = ramRdData;

endmodule : fifoFlops

`default_nettype wire

//--- source/laneSpreader.sv
// --------------------
// Round-robin lane spreader
// Sends each accepted input beat to the next lane FIFO in turn
// --------------------

`timescale 1ns/1ps
`default_nettype none

module laneSpreader (
  // Posedge clock
  input  logic                                  clk,
  // Asynchronous active-low reset
  input  logic                                  rstN,

  // Input stream
  input  logic                                  inValid,
  input  stripedFifoPkg::beat_t                 inBeat,
  output logic                                  inReady,

  // Push side of every lane
  output logic [stripedFifoPkg::NumLanes-1:0]   pushValid,
  output stripedFifoPkg::beat_t                 pushBeat,
  input  logic [stripedFifoPkg::NumLanes-1:0]   pushReady
);

  // --------------------
  // Lane pointer
  // --------------------

  // Lane that takes the next input beat
  stripedFifoPkg::laneIdx_t ptr;
  logic                     accept;

  assign accept = inValid && inReady;

  // Only an accepted beat moves the pointer on
  // A full lane therefore stalls the input instead of being skipped,
  // which keeps the lane order the gatherer expects
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ptr <= '0;
    end else if (accept) begin
      if (int'(ptr) == stripedFifoPkg::NumLanes - 1) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // --------------------
  // Routing
  // --------------------

  // Valid reaches the pointed lane only
  always_comb begin
    pushValid      = '0;
    pushValid[ptr] = inValid;
  end

  // The beat itself is fanned out, the valid decides who takes it
  assign pushBeat = inBeat;
  assign inReady  = pushReady[ptr];

endmodule : laneSpreader

`default_nettype wire

//--- source/laneGatherer.sv
// --------------------
// Round-robin lane gatherer
// Pops the lanes in the spreader's order and drives the output stream
// --------------------

`timescale 1ns/1ps
`default_nettype none

module laneGatherer (
  // Posedge clock
  input  logic                                                 clk,
  // Asynchronous active-low reset
  input  logic                                                 rstN,

  // Pop side of every lane
  input  logic [stripedFifoPkg::NumLanes-1:0]                  popValid,
  input  stripedFifoPkg::beat_t [stripedFifoPkg::NumLanes-1:0] popBeat,
  output logic [stripedFifoPkg::NumLanes-1:0]                  popReady,

  // Output stream
  output logic                                                 outValid,
  output stripedFifoPkg::beat_t                                outBeat,
  input  logic                                                 outReady
);

  // --------------------
  // Lane pointer
  // --------------------

  // Lane that holds the oldest beat of the whole subsystem
  stripedFifoPkg::laneIdx_t ptr;
  logic                     transfer;

  assign transfer = outValid && outReady;

  // Same start lane and same step as the spreader, so beats leave in the
  // order they came in
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ptr <= '0;
    end else if (transfer) begin
      if (int'(ptr) == stripedFifoPkg::NumLanes - 1) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // --------------------
  // Output mux
  // --------------------

  assign outValid = popValid[ptr];
  assign outBeat  = popBeat[ptr];

  // Ready goes back to the pointed lane only, all others hold their heads
  always_comb begin
    popReady      = '0;
    popReady[ptr] = outReady;
  end

endmodule : laneGatherer

`default_nettype wire

//--- source/stripedFifo.sv
// --------------------
// Striped flop-RAM FIFO top
// Spreads one ready/valid stream over NumLanes lane FIFOs and gathers it
// back in order, each lane running at a fraction of the stream rate
// --------------------

`timescale 1ns/1ps
`default_nettype none

module stripedFifo (
  // Posedge clock
  input  logic                  clk,
  // Asynchronous active-low reset
  input  logic                  rstN,

  // Input stream
  input  logic                  inValid,
  input  stripedFifoPkg::beat_t inBeat,
  output logic                  inReady,

  // Output stream
  output logic                  outValid,
  output stripedFifoPkg::beat_t outBeat,
  input  logic                  outReady,

  // High when every lane is empty
  output logic                  idle
);

  // --------------------
  // Lane wiring
  // --------------------

  logic [stripedFifoPkg::NumLanes-1:0]                  pushValid;
  stripedFifoPkg::beat_t                                pushBeat;
  logic [stripedFifoPkg::NumLanes-1:0]                  pushReady;
  logic [stripedFifoPkg::NumLanes-1:0]                  popValid;
  stripedFifoPkg::beat_t [stripedFifoPkg::NumLanes-1:0] popBeat;
  logic [stripedFifoPkg::NumLanes-1:0]                  popReady;
  logic [stripedFifoPkg::NumLanes-1:0]                  laneEmpty;

  laneSpreader laneSpreader (
    .clk,
    .rstN,
    .inValid,
    .inBeat,
    .inReady,
    .pushValid,
    .pushBeat,
    .pushReady
  );

  // One lane FIFO per stripe, all fed the same fanned-out beat
  // Only the empty flag of each lane is needed up here
  for (genvar i = 0; i < stripedFifoPkg::NumLanes; i++) begin : gLane
    fifoFlops fifoFlops (
      .clk,
      .rstN,
      .pushValid(pushValid[i]),
      .pushBeat (pushBeat),
      .pushReady(pushReady[i]),
      .popValid (popValid[i]),
      .popBeat  (popBeat[i]),
      .popReady (popReady[i]),
      .full     (),
      .empty    (laneEmpty[i]),
      .items    (),
      .slots    ()
    );
  end

  laneGatherer laneGatherer (
    .clk,
    .rstN,
    .popValid,
    .popBeat,
    .popReady,
    .outValid,
    .outBeat,
    .outReady
  );

  // Nothing is held anywhere once all lanes report empty
  assign idle = &laneEmpty;

endmodule : stripedFifo

`default_nettype wire

//--- tb/stripedFifo_assert.sv
// --------------------
// Striped FIFO stream protocol checks
// Watches both stream ports and the idle flag of the top level
// --------------------

`timescale 1ns/1ps
`default_nettype none

module stripedFifo_assert (
  input logic                  clk,
  input logic                  rstN,
  input logic                  inValid,
  input stripedFifoPkg::beat_t inBeat,
  input logic                  inReady,
  input logic                  outValid,
  input stripedFifoPkg::beat_t outBeat,
  input logic                  outReady,
  input logic                  idle
);

  // A stalled input beat must not change until it is taken
  inHold: assert property (@(posedge clk) disable iff (!rstN)
    inValid && !inReady |=> $stable(inBeat))
    else $error("inBeat changed while stalled on inReady");

  // Under back-pressure the offered output beat stays put
  outHold: assert property (@(posedge clk) disable iff (!rstN)
    outValid && !outReady |=> outValid && $stable(outBeat))
    else $error("outValid or outBeat changed while stalled on outReady");

  // An output beat is offered exactly when some lane holds a beat
  // The gatherer's lane then always carries the oldest beat
  idleQuiet: assert property (@(posedge clk) disable iff (!rstN) idle != outValid)
    else $error("idle and outValid disagree about pending beats");

endmodule : stripedFifo_assert

`default_nettype wire

//--- tb/stripedFifo_tb.sv
// --------------------
// Striped FIFO testbench
// Drives both streams on the falling edge and checks every output beat
// against an in-order queue model of the accepted beats
// --------------------

`timescale 1ns/1ps
`default_nettype none

module stripedFifo_tb;

  // Cycle limits for a single handshake and for the whole random run
  localparam int HandshakeTimeout = 100;
  localparam int RandomTimeout    = 20000;

  logic                  clk;
  logic                  rstN;
  logic                  inValid;
  stripedFifoPkg::beat_t inBeat;
  logic                  inReady;
  logic                  outValid;
  stripedFifoPkg::beat_t outBeat;
  logic                  outReady;
  logic                  idle;

  // Beats accepted by the DUT and not yet seen at the output, oldest first
  stripedFifoPkg::beat_t modelQ[$];
  int                    inCount;
  int                    outCount;
  int                    errorCount;
  string                 testName;

  stripedFifo i_dut (
    .clk, .rstN, .inValid, .inBeat, .inReady, .outValid, .outBeat, .outReady, .idle
  );

  bind stripedFifo stripedFifo_assert i_assert (
    .clk, .rstN, .inValid, .inBeat, .inReady, .outValid, .outBeat, .outReady, .idle
  );

  always #2 clk = ~clk;

  // --------------------
  // Checks and model
  // --------------------

  task automatic stopOnFailure();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic checkBeat(input string name, input stripedFifoPkg::beat_t expected,
                           input stripedFifoPkg::beat_t actual);
    if (actual !== expected) begin
      errorCount++;
      $display("** Error %s: expected data=%h last=%b, actual data=%h last=%b",
               name, expected.data, expected.last, actual.data, actual.last);
      stopOnFailure();
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errorCount++;
      $display("** Error %s: expected %b, actual %b", name, expected, actual);
      stopOnFailure();
    end
  endtask

  // The output order has to equal the acceptance order, so the oldest beat is next
  function automatic stripedFifoPkg::beat_t nextExpected();
    return modelQ.pop_front();
  endfunction

  function automatic stripedFifoPkg::beat_t makeBeat();
    stripedFifoPkg::beat_t b;
    b.data = $urandom;
    b.last = ($urandom % 2) == 1;
    return b;
  endfunction

  // Records every accepted input beat and compares every output transfer
  always @(posedge clk) begin
    if (rstN) begin
      if (outValid && outReady) begin
        if (modelQ.size() == 0) begin
          $display("Output transfer in %s while no accepted beat is outstanding", testName);
          stopOnFailure();
        end else begin
          checkBeat(testName, nextExpected(), outBeat);
        end
        outCount++;
      end
      if (inValid && inReady) begin
        modelQ.push_back(inBeat);
        inCount++;
      end
    end
  end

  // --------------------
  // Stimulus helpers
  // --------------------

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic sendBeat(input stripedFifoPkg::beat_t b);
    int base;
    int waits;
    base    = inCount;
    waits   = 0;
    inBeat  = b;
    inValid = 1'b1;
    while (inCount == base) begin
      if (waits == HandshakeTimeout) begin
        $display("Timeout in %s: input beat not accepted within %0d cycles",
                 testName, HandshakeTimeout);
        stopOnFailure();
      end
      @(negedge clk);
      waits++;
    end
  endtask

  task automatic waitOutputs(input int target);
    int waits;
    waits = 0;
    while (outCount < target) begin
      if (waits == HandshakeTimeout * 4) begin
        $display("Timeout in %s: only %0d of %0d output beats seen", testName, outCount, target);
        stopOnFailure();
      end
      @(negedge clk);
      waits++;
    end
  endtask

  task automatic waitIdle();
    int waits;
    waits = 0;
    while (idle !== 1'b1) begin
      if (waits == HandshakeTimeout) begin
        $display("Timeout in %s: idle never rose", testName);
        stopOnFailure();
      end
      @(negedge clk);
      waits++;
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    int base;
    int offered;
    int heldAt;
    int cycles;
    void'($urandom(61047));
    clk        = 1'b0;
    rstN       = 1'b0;
    inValid    = 1'b0;
    inBeat     = '0;
    outReady   = 1'b0;
    inCount    = 0;
    outCount   = 0;
    errorCount = 0;
    testName   = "reset";
    repeat (2) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);
    checkFlag("reset idle", 1'b1, idle);
    checkFlag("reset inReady", 1'b1, inReady);
    checkFlag("reset outValid", 1'b0, outValid);

    // One beat into an empty DUT shows up right after the edge that took it
    testName = "single beat";
    outReady = 1'b1;
    sendBeat(makeBeat());
    inValid = 1'b0;
    checkFlag("single beat outValid", 1'b1, outValid);
    waitOutputs(1);
    waitIdle();

    // Every lane fills to LaneDepth, then the input has to stall
    testName = "fill";
    outReady = 1'b0;
    base     = outCount;
    for (int i = 0; i < stripedFifoPkg::NumLanes * stripedFifoPkg::LaneDepth; i++) begin
      checkFlag("fill inReady", 1'b1, inReady);
      sendBeat(makeBeat());
    end
    inValid = 1'b0;
    repeat (4) begin
      checkFlag("full inReady", 1'b0, inReady);
      @(negedge clk);
    end
    outReady = 1'b1;
    waitOutputs(base + stripedFifoPkg::NumLanes * stripedFifoPkg::LaneDepth);
    checkFlag("drained idle", 1'b1, idle);

    // Back-to-back beats, one per cycle on both sides
    testName = "streaming";
    base     = outCount;
    for (int i = 0; i < 200; i++) begin
      checkFlag("streaming inReady", 1'b1, inReady);
      if (i > 0) begin
        checkFlag("streaming outValid", 1'b1, outValid);
      end
      sendBeat(makeBeat());
    end
    inValid = 1'b0;
    waitOutputs(base + 200);

    // Random gaps on the input and random back-pressure on the output
    testName = "random stalls";
    base     = inCount + 1000;
    offered  = 0;
    heldAt   = inCount;
    cycles   = 0;
    while (inCount < base) begin
      if (!inValid || inCount != heldAt) begin
        if (offered < 1000 && ($urandom % 4) != 0) begin
          inBeat  = makeBeat();
          inValid = 1'b1;
          heldAt  = inCount;
          offered++;
        end else begin
          inValid = 1'b0;
        end
      end
      outReady = ($urandom % 3) != 0;
      @(negedge clk);
      cycles++;
      if (cycles == RandomTimeout) begin
        $display("Timeout in %s: %0d of 1000 beats accepted", testName, inCount + 1000 - base);
        stopOnFailure();
      end
    end

    // Drain the rest, idle may only rise once every accepted beat has left
    inValid  = 1'b0;
    outReady = 1'b1;
    waitIdle();
    checkFlag("model queue empty at idle", 1'b1, modelQ.size() == 0);

    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : stripedFifo_tb

`default_nettype wire

//--- stripedFifo.f
source/stripedFifoPkg.sv
source/flopRam.sv
source/fifoFlops.sv
source/laneSpreader.sv
source/laneGatherer.sv
source/stripedFifo.sv
tb/stripedFifo_assert.sv
tb/stripedFifo_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the striped FIFO testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f stripedFifo.f --top-module stripedFifo_tb -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  echo "Testbench reported a failure"
  exit 1
fi

if ! grep -q "=== PASS ===" "$LOG"; then
  echo "Testbench did not report a result"
  exit 1
fi

exit 0
